// ==== Makefile ====
# Verilator build and run for the command decoder testbench

VERILATOR ?= verilator
TOP       ?= tb_cmd_decoder
FLIST     ?= cmd_decoder_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cmd_decoder_top.f ====
hw/cmd_pkg.sv
hw/buff_pkg.sv
hw/cmd_word_decode.sv
hw/mode_buff_regs.sv
hw/buff_readout.sv
hw/cmd_decoder_top.sv
verif/cmd_decoder_chk.sv
verif/tb_cmd_decoder.sv

// ==== hw/buff_pkg.sv ====
package buff_pkg;

    import cmd_pkg::*;

    localparam int RD_W = 17;  // Width of group B, the widest group

    typedef enum logic [1:0] {
        GRP_A    = 2'd0,
        GRP_B    = 2'd1,
        GRP_MODE = 2'd2
    } grp_e;

    // First member lands in the top bits, so group A occupies bank bits 2:0
    typedef struct packed {
        logic [1:0]  grp_mode;
        logic [16:0] grp_b;
        logic [2:0]  grp_a;
    } buff_bank_t;

    localparam logic [NUM_BITS-1:0] GRP_MASK [0:2] = '{
        buff_bank_t'{grp_mode: '0, grp_b: '0, grp_a: '1},
        buff_bank_t'{grp_mode: '0, grp_b: '1, grp_a: '0},
        buff_bank_t'{grp_mode: '1, grp_b: '0, grp_a: '0}
    };

endpackage

// ==== hw/buff_readout.sv ====
`timescale 1ns/1ps

module buff_readout
    import buff_pkg::*;
(
    input  logic            sim_clk,
    input  logic            arst_n,
    input  buff_bank_t      bank,
    input  grp_e            rd_sel,
    output logic [RD_W-1:0] rd_data,
    output logic            changed
);

    buff_bank_t      bank_prev;
    logic [RD_W-1:0] sel_data;
    logic [RD_W-1:0] rd_q;
    logic            changed_q;

    always_comb begin
        case (rd_sel)
            GRP_A: begin
                sel_data = RD_W'(bank.grp_a);
            end
            GRP_B: begin
                sel_data = bank.grp_b;
            end
            GRP_MODE: begin
                sel_data = RD_W'(bank.grp_mode);
            end
            default: begin
                sel_data = '0;
            end
        endcase
    end

    // Previous copy starts at zero like the bank, so reset gives no pulse
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            bank_prev <= '0;
            rd_q      <= '0;
            changed_q <= 1'b0;
        end else begin
            bank_prev <= bank;
            rd_q      <= sel_data;
            changed_q <= (bank != bank_prev);
        end
    end

    assign rd_data = rd_q;
    assign changed = changed_q;

endmodule

// ==== hw/cmd_decoder_top.sv ====
`timescale 1ns/1ps

module cmd_decoder_top
    import cmd_pkg::*;
    import buff_pkg::*;
(
    input  logic            sim_clk,
    input  logic            arst_n,
    input  logic            word_strobe,
    input  cmd_word_t       word,
    input  grp_e            rd_sel,
    output buff_bank_t      bank,
    output logic [RD_W-1:0] rd_data,
    output logic            changed
);

    dec_op_t dec_op;  // Decoded word, one cycle behind the strobe

    cmd_word_decode u_decode (
        .sim_clk     (sim_clk),
        .arst_n      (arst_n),
        .word_strobe (word_strobe),
        .word        (word),
        .dec_op      (dec_op)
    );

    mode_buff_regs u_regs (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .dec_op  (dec_op),
        .bank    (bank)
    );

    buff_readout u_readout (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .bank    (bank),
        .rd_sel  (rd_sel),
        .rd_data (rd_data),
        .changed (changed)
    );

endmodule

// ==== hw/cmd_pkg.sv ====
package cmd_pkg;

    localparam int DATA_W   = 7;
    localparam int NUM_BITS = 22;  // 20 buffer bits and 2 mode bits

    // Spare code 3'd7 is left unnamed and decodes as NOP
    typedef enum logic [2:0] {
        NOP      = 3'd0,
        SET_A    = 3'd1,
        SET_B    = 3'd2,
        SET_MODE = 3'd3,
        CLR_A    = 3'd4,
        CLR_B    = 3'd5,
        CLR_MODE = 3'd6
    } word_type_e;

    typedef struct packed {
        word_type_e        wtype;
        logic [DATA_W-1:0] data;  // data[0] is G1, data[6] is G7
    } cmd_word_t;

    typedef struct packed {
        word_type_e grp;  // SET word type that addresses the bit
        logic [2:0] hi;
        logic [2:0] lo;
    } set_term_t;

    // Entry k drives bank bit k when data[hi] is 1 and data[lo] is 0
    localparam set_term_t SET_TABLE [0:NUM_BITS-1] = '{
        '{SET_A,    3'd2, 3'd1},  // Group A starts at bit 0
        '{SET_A,    3'd3, 3'd2},
        '{SET_A,    3'd0, 3'd1},
        '{SET_B,    3'd1, 3'd2},  // Group B starts at bit 3
        '{SET_B,    3'd2, 3'd3},
        '{SET_B,    3'd3, 3'd4},  // G4 high, G5 low
        '{SET_B,    3'd4, 3'd5},
        '{SET_B,    3'd5, 3'd6},
        '{SET_B,    3'd6, 3'd0},
        '{SET_B,    3'd1, 3'd0},
        '{SET_B,    3'd2, 3'd1},
        '{SET_B,    3'd3, 3'd2},
        '{SET_B,    3'd4, 3'd3},
        '{SET_B,    3'd5, 3'd4},
        '{SET_B,    3'd6, 3'd5},
        '{SET_B,    3'd0, 3'd6},
        '{SET_B,    3'd0, 3'd2},
        '{SET_B,    3'd1, 3'd3},
        '{SET_B,    3'd2, 3'd4},
        '{SET_B,    3'd3, 3'd5},
        '{SET_MODE, 3'd0, 3'd1},  // Mode bits sit at the top of the bank
        '{SET_MODE, 3'd1, 3'd2}
    };

    typedef struct packed {
        logic [NUM_BITS-1:0] set_vec;
        logic                clr_a;
        logic                clr_b;
        logic                clr_mode;
        logic                op_valid;
    } dec_op_t;

endpackage

// ==== hw/cmd_word_decode.sv ====
`timescale 1ns/1ps

module cmd_word_decode
    import cmd_pkg::*;
(
    input  logic      sim_clk,
    input  logic      arst_n,
    input  logic      word_strobe,
    input  cmd_word_t word,
    output dec_op_t   dec_op
);

    logic [NUM_BITS-1:0] term_hit;
    dec_op_t             op_nxt;
    dec_op_t             op_q;

    // Every table entry is checked in parallel, as the gate terms of each latch are
    always_comb begin
        for (int k = 0; k < NUM_BITS; k++) begin
            term_hit[k] = word.data[SET_TABLE[k].hi]
                        & ~word.data[SET_TABLE[k].lo]
                        & (word.wtype == SET_TABLE[k].grp);
        end
    end

    always_comb begin
        op_nxt          = '0;
        op_nxt.op_valid = word_strobe;
        if (word_strobe) begin
            case (word.wtype)
                SET_A, SET_B, SET_MODE: begin
                    op_nxt.set_vec = term_hit;  // Hits are already limited to the word's group
                end
                CLR_A: begin
                    op_nxt.clr_a = 1'b1;
                end
                CLR_B: begin
                    op_nxt.clr_b = 1'b1;
                end
                CLR_MODE: begin
                    op_nxt.clr_mode = 1'b1;
                end
                default: begin
                    op_nxt.set_vec = '0;  // NOP and the spare code
                end
            endcase
        end
    end

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            op_q <= '0;
        end else begin
            op_q <= op_nxt;
        end
    end

    assign dec_op = op_q;

endmodule

// ==== hw/mode_buff_regs.sv ====
`timescale 1ns/1ps

module mode_buff_regs
    import cmd_pkg::*;
    import buff_pkg::*;
(
    input  logic       sim_clk,
    input  logic       arst_n,
    input  dec_op_t    dec_op,
    output buff_bank_t bank
);

    logic [NUM_BITS-1:0] clr_mask;
    logic [NUM_BITS-1:0] set_term;
    logic [NUM_BITS-1:0] rst_term;
    logic [NUM_BITS-1:0] latch_q;

    // Group clears play the part of the BRR1, BRR2 and MODRR reset lines
    always_comb begin
        clr_mask = '0;
        if (dec_op.clr_a) begin
            clr_mask = clr_mask | GRP_MASK[GRP_A];
        end
        if (dec_op.clr_b) begin
            clr_mask = clr_mask | GRP_MASK[GRP_B];
        end
        if (dec_op.clr_mode) begin
            clr_mask = clr_mask | GRP_MASK[GRP_MODE];
        end
    end

    assign set_term = dec_op.op_valid ? dec_op.set_vec : '0;
    assign rst_term = dec_op.op_valid ? clr_mask : '0;

    // One set/reset latch per bit, held in place when neither input is active
    for (genvar k = 0; k < NUM_BITS; k++) begin : g_latch
        logic q;

        always_ff @(posedge sim_clk or negedge arst_n) begin
            if (!arst_n) begin
                q <= 1'b0;
            end else if (set_term[k]) begin
                q <= 1'b1;
            end else if (rst_term[k]) begin
                q <= 1'b0;
            end
        end

        assign latch_q[k] = q;
    end

    assign bank = buff_bank_t'(latch_q);

endmodule

// ==== verif/cmd_decoder_chk.sv ====
`timescale 1ns/1ps

module cmd_decoder_chk
    import cmd_pkg::*;
    import buff_pkg::*;
(
    input logic       sim_clk,
    input logic       arst_n,
    input dec_op_t    dec_op,
    input buff_bank_t bank
);

    logic [NUM_BITS-1:0] bits;
    logic [NUM_BITS-1:0] clr_mask;
    logic                op_clr;
    int unsigned         fail_cnt = 0;  // Read by the testbench at the end of the run

    assign bits     = bank;
    assign clr_mask = (dec_op.clr_a ? GRP_MASK[GRP_A] : '0)
                    | (dec_op.clr_b ? GRP_MASK[GRP_B] : '0)
                    | (dec_op.clr_mode ? GRP_MASK[GRP_MODE] : '0);
    assign op_clr   = dec_op.op_valid & (dec_op.clr_a | dec_op.clr_b | dec_op.clr_mode);

    a_reset_zero: assert property (@(posedge sim_clk) $rose(arst_n) |-> bits == '0)
        else begin
            $error("latch bank is not all zero when reset is released");
            fail_cnt++;
        end

    // Only bits inside the cleared group may fall
    a_clr_scope: assert property (@(posedge sim_clk) disable iff (!arst_n)
        op_clr |=> ($past(bits) & ~$past(clr_mask) & ~bits) == '0)
        else begin
            $error("a bit outside the cleared group fell");
            fail_cnt++;
        end

    a_fall_on_clr: assert property (@(posedge sim_clk) disable iff (!arst_n)
        !op_clr |=> ($past(bits) & ~bits) == '0)
        else begin
            $error("a latch bit fell without a valid clear");
            fail_cnt++;
        end

endmodule

bind mode_buff_regs cmd_decoder_chk u_chk (
    .sim_clk (sim_clk),
    .arst_n  (arst_n),
    .dec_op  (dec_op),
    .bank    (bank)
);

// ==== verif/tb_cmd_decoder.sv ====
`timescale 1ns/1ps

module tb_cmd_decoder
    import cmd_pkg::*;
    import buff_pkg::*;
();

    localparam int N_RAND      = 200;
    localparam int STIM_CYCLES = 4 + NUM_BITS * 4 + 3 * 7 + 8 + N_RAND + 6;
    localparam int MAX_CYCLES  = 4 * STIM_CYCLES + 50;

    logic            sim_clk;
    logic            arst_n;
    logic            word_strobe;
    cmd_word_t       word;
    grp_e            rd_sel;
    buff_bank_t      bank;
    logic [RD_W-1:0] rd_data;
    logic            changed;

    buff_bank_t model;
    buff_bank_t exp_q[$];  // One entry per cycle, two cycles ahead of bank
    buff_bank_t exp_prev;
    buff_bank_t exp_prev2;
    grp_e       sel_prev;
    logic       checking;
    int         n_checks;
    int         n_errors;
    int         cycle_cnt = 0;

    cmd_decoder_top dut (
        .sim_clk     (sim_clk),
        .arst_n      (arst_n),
        .word_strobe (word_strobe),
        .word        (word),
        .rd_sel      (rd_sel),
        .bank        (bank),
        .rd_data     (rd_data),
        .changed     (changed)
    );

    initial begin
        sim_clk = 1'b0;
        forever #2 sim_clk = ~sim_clk;
    end

    // Reference: next bank from the current bank and one strobed word
    function automatic buff_bank_t next_bank(buff_bank_t cur, cmd_word_t w);
        logic [NUM_BITS-1:0] bits;
        bits = cur;
        case (w.wtype)
            CLR_A:    bits = bits & ~GRP_MASK[GRP_A];
            CLR_B:    bits = bits & ~GRP_MASK[GRP_B];
            CLR_MODE: bits = bits & ~GRP_MASK[GRP_MODE];
            SET_A, SET_B, SET_MODE: begin
                for (int k = 0; k < NUM_BITS; k++) begin
                    if (SET_TABLE[k].grp == w.wtype && w.data[SET_TABLE[k].hi]
                        && !w.data[SET_TABLE[k].lo]) begin
                        bits[k] = 1'b1;
                    end
                end
            end
            default: ;
        endcase
        return buff_bank_t'(bits);
    endfunction

    function automatic logic [RD_W-1:0] group_bits(buff_bank_t b, grp_e g);
        case (g)
            GRP_A:    return RD_W'(b.grp_a);
            GRP_B:    return b.grp_b;
            GRP_MODE: return RD_W'(b.grp_mode);
            default:  return '0;
        endcase
    endfunction

    function automatic cmd_word_t make_word(word_type_e t, logic [DATA_W-1:0] d);
        cmd_word_t w;
        w.wtype = t;
        w.data  = d;
        return w;
    endfunction

    function automatic word_type_e clr_type(word_type_e s);
        case (s)
            SET_A:   return CLR_A;
            SET_B:   return CLR_B;
            default: return CLR_MODE;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
        n_checks++;
        if (exp_val !== act_val) begin
            n_errors++;
            $display("ERR %0t %s exp=0x%0h act=0x%0h", $time, name, exp_val, act_val);
        end
    endtask

    task automatic send_word(input cmd_word_t w, input logic strobe);
        @(posedge sim_clk);
        word_strobe <= strobe;
        word        <= w;
        rd_sel      <= grp_e'(2'($urandom_range(2, 0)));
        if (strobe) begin
            model = next_bank(model, w);
        end
        exp_q.push_back(model);
    endtask

    always @(negedge sim_clk) begin
        buff_bank_t exp_now;
        if (checking && exp_q.size() >= 3) begin
            exp_now = exp_q.pop_front();
            check_val("bank", 32'(exp_now), 32'(bank));
            check_val("rd_data", 32'(group_bits(exp_prev, sel_prev)), 32'(rd_data));
            check_val("changed", 32'(exp_prev != exp_prev2), 32'(changed));
            exp_prev2 = exp_prev;
            exp_prev  = exp_now;
        end
        sel_prev = rd_sel;  // The DUT samples this value on the next rising edge
    end

    always @(posedge sim_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish");
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(43));
        arst_n      = 1'b0;
        word_strobe = 1'b0;
        word        = '0;
        rd_sel      = GRP_A;
        model       = '0;
        exp_prev    = '0;
        exp_prev2   = '0;
        sel_prev    = GRP_A;
        checking    = 1'b0;
        n_checks    = 0;
        n_errors    = 0;
        repeat (3) @(posedge sim_clk);
        arst_n <= 1'b1;
        @(negedge sim_clk);
        check_val("bank", 32'h0, 32'(bank));
        check_val("rd_data", 32'h0, 32'(rd_data));
        check_val("changed", 32'h0, 32'(changed));
        exp_q.push_back(model);
        exp_q.push_back(model);
        checking = 1'b1;

        // Each table entry with its matching word and with its low bit alone
        for (int k = 0; k < NUM_BITS; k++) begin
            send_word(make_word(clr_type(SET_TABLE[k].grp), '0), 1'b1);
            send_word(make_word(SET_TABLE[k].grp, 7'b1 << SET_TABLE[k].hi), 1'b1);
            send_word(make_word(clr_type(SET_TABLE[k].grp), '0), 1'b1);
            send_word(make_word(SET_TABLE[k].grp, 7'b1 << SET_TABLE[k].lo), 1'b1);
        end

        for (int g = 0; g < 3; g++) begin
            repeat (6) begin
                send_word(make_word(word_type_e'(3'($urandom_range(3, 1))), 7'($urandom)), 1'b1);
            end
            send_word(make_word(word_type_e'(3'(4 + g)), 7'($urandom)), 1'b1);
        end

        repeat (4) begin
            send_word(make_word(word_type_e'(3'($urandom_range(3, 1))), 7'($urandom)), 1'b1);
        end
        send_word(make_word(NOP, 7'($urandom)), 1'b1);
        send_word(make_word(word_type_e'(3'd7), 7'h2a), 1'b1);  // Spare code, data hits all groups
        send_word(make_word(NOP, '0), 1'b1);
        send_word(make_word(NOP, '0), 1'b0);

        repeat (N_RAND) begin
            send_word(make_word(word_type_e'(3'($urandom)), 7'($urandom)),
                      $urandom_range(7, 0) != 0);
        end
        repeat (4) send_word(make_word(NOP, '0), 1'b0);
        repeat (2) @(negedge sim_clk);

        $display("checks %0d, value errors %0d, assertion failures %0d",
                 n_checks, n_errors, dut.u_regs.u_chk.fail_cnt);
        if (n_errors == 0 && dut.u_regs.u_chk.fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
